/* eth_rx.f */
+incdir+hdl
hdl/eth_rx_pkg.sv
hdl/eth_rx_nibble_asm.sv
hdl/eth_rx_crc32.sv
hdl/eth_rx_frame_buf.sv
hdl/eth_rx_ctrl.sv
hdl/eth_rx_top.sv
test/eth_rx_tb_clk.sv
test/eth_rx_asserts.sv
test/eth_rx_tb.sv

/* hdl/eth_rx_consts.svh */
`ifndef ETH_RX_CONSTS_SVH
`define ETH_RX_CONSTS_SVH

// Start-of-frame delimiter as seen after nibble assembly
`define ETH_RX_SFD 8'hd5

// Station address, first received byte in the top octet
`define ETH_RX_MAC_ADDR 48'h02_11_22_33_44_55

`define ETH_RX_MAC_LEN 6

// CRC register value after a good frame with its FCS
`define ETH_RX_CRC_RESIDUE 32'hc704dd7b

`define ETH_RX_AW 11

`endif

/* hdl/eth_rx_crc32.sv */
`timescale 1ns/1ps

module eth_rx_crc32 (
   input  logic                rx_clk_i,
   input  logic                arst_i,
   input  logic                start_i,
   input  eth_rx_pkg::buf_wr_t wr_i,
   output logic [31:0]         crc_o
);

   localparam logic [31:0] POLY = 32'h04c11db7;

   logic [31:0] crc_q;
   logic [31:0] crc_nxt;

   // Ethernet sends each byte LSB first, so data enters from bit 0
   always_comb begin
      crc_nxt = crc_q;
      for (int i = 0; i < 8; i++) begin
         if (crc_nxt[31] ^ wr_i.data[i]) begin
            crc_nxt = {crc_nxt[30:0], 1'b0} ^ POLY;
         end else begin
            crc_nxt = {crc_nxt[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         crc_q <= '1;
      end else if (start_i) begin
         crc_q <= '1;
      end else if (wr_i.en) begin
         crc_q <= crc_nxt;
      end
   end

   assign crc_o = crc_q;

endmodule

/* hdl/eth_rx_ctrl.sv */
`timescale 1ns/1ps
`include "eth_rx_consts.svh"

module eth_rx_ctrl (
   input  logic                   rx_clk_i,
   input  logic                   arst_i,
   input  logic                   rx_dv_i,
   input  eth_rx_pkg::rx_byte_t   cand_i,
   input  logic                   rcv_ack_i,
   input  logic [31:0]            crc_i,
   output logic                   align_o,
   output logic                   crc_start_o,
   output eth_rx_pkg::buf_wr_t    wr_o,
   output eth_rx_pkg::rx_status_t status_o
);

   eth_rx_pkg::ctrl_state_e state;

   logic [11:0] cnt;
   logic [47:0] dest;
   logic [47:0] dest_nxt;
   logic        dest_ok;
   logic        wr_req;

   assign align_o = (state == eth_rx_pkg::IDLE) && rx_dv_i && cand_i.vld &&
                    (cand_i.data == `ETH_RX_SFD);

   assign crc_start_o = (state == eth_rx_pkg::IDLE);

   assign wr_req = cand_i.vld &&
                   ((state == eth_rx_pkg::DEST) || (state == eth_rx_pkg::PAYLOAD));

   // Destination check uses the byte arriving this cycle
   assign dest_nxt = {dest[39:0], cand_i.data};
   assign dest_ok  = (dest_nxt == `ETH_RX_MAC_ADDR) || (dest_nxt == {48{1'b1}});

   always_ff @(posedge rx_clk_i) begin
      if ((state == eth_rx_pkg::DEST) && cand_i.vld) begin
         dest <= dest_nxt;
      end
   end

   // Registered buffer write, one cycle behind the byte strobe
   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_o <= '0;
         cnt  <= '0;
      end else begin
         wr_o.en <= 1'b0;
         if (align_o) begin
            cnt <= '0;
         end else if (wr_req) begin
            wr_o.en   <= 1'b1;
            wr_o.addr <= cnt[`ETH_RX_AW-1:0];
            wr_o.data <= cand_i.data;
            cnt       <= cnt + 12'd1;
         end
      end
   end

   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         state    <= eth_rx_pkg::IDLE;
         status_o <= '0;
      end else begin
         case (state)
            eth_rx_pkg::IDLE: begin
               if (align_o) begin
                  state <= eth_rx_pkg::DEST;
               end
            end
            eth_rx_pkg::DEST: begin
               if (!rx_dv_i) begin
                  state <= eth_rx_pkg::DRAIN;
               end else if (cand_i.vld && (cnt == 12'(`ETH_RX_MAC_LEN - 1))) begin
                  state <= dest_ok ? eth_rx_pkg::PAYLOAD : eth_rx_pkg::DRAIN;
               end
            end
            eth_rx_pkg::PAYLOAD: begin
               if (!rx_dv_i) begin
                  state <= eth_rx_pkg::DONE;
               end
            end
            eth_rx_pkg::DONE: begin
               // First cycle here, the CRC has taken the last byte
               if (!status_o.rcvd) begin
                  status_o.rcvd    <= 1'b1;
                  status_o.crc_err <= (crc_i != `ETH_RX_CRC_RESIDUE);
                  status_o.len     <= cnt;
               end else if (rcv_ack_i) begin
                  status_o <= '0;
                  state    <= eth_rx_pkg::DRAIN;
               end
            end
            eth_rx_pkg::DRAIN: begin
               if (!rx_dv_i) begin
                  state <= eth_rx_pkg::IDLE;
               end
            end
            default: begin
               state <= eth_rx_pkg::IDLE;
            end
         endcase
      end
   end

endmodule

/* hdl/eth_rx_frame_buf.sv */
`timescale 1ns/1ps
`include "eth_rx_consts.svh"

module eth_rx_frame_buf (
   input  logic                  rx_clk_i,
   input  eth_rx_pkg::buf_wr_t   wr_i,
   input  logic [`ETH_RX_AW-1:0] rd_addr_i,
   output logic [7:0]            rd_data_o
);

   localparam int DEPTH = 2 ** `ETH_RX_AW;

   logic [7:0] mem [0:DEPTH-1];

   always_ff @(posedge rx_clk_i) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // One cycle read latency
   always_ff @(posedge rx_clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

/* hdl/eth_rx_nibble_asm.sv */
`timescale 1ns/1ps

module eth_rx_nibble_asm (
   input  logic                 rx_clk_i,
   input  logic                 arst_i,
   input  logic                 rx_dv_i,
   input  logic [3:0]           rx_data_i,
   input  logic                 align_i,
   output eth_rx_pkg::rx_byte_t cand_o
);

   logic [3:0] hi_q;
   logic       phase;
   logic       locked;

   // Previous nibble becomes the low half of the next candidate
   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         hi_q <= '0;
      end else if (rx_dv_i) begin
         hi_q <= rx_data_i;
      end
   end

   // Phase runs free while hunting, restarts on delimiter
   always_ff @(posedge rx_clk_i or posedge arst_i) begin
      if (arst_i) begin
         phase  <= 1'b0;
         locked <= 1'b0;
      end else if (!rx_dv_i) begin
         phase  <= 1'b0;
         locked <= 1'b0;
      end else if (align_i) begin
         phase  <= 1'b0;
         locked <= 1'b1;
      end else begin
         phase <= ~phase;
      end
   end

   assign cand_o.data = {rx_data_i, hi_q};
   assign cand_o.vld  = rx_dv_i && (!locked || phase);

endmodule

/* hdl/eth_rx_pkg.sv */
`include "eth_rx_consts.svh"

package eth_rx_pkg;

   typedef enum logic [2:0] {
      IDLE,
      DEST,
      PAYLOAD,
      DONE,
      DRAIN
   } ctrl_state_e;

   typedef struct packed {
      logic [7:0] data;
      logic       vld;
   } rx_byte_t;

   typedef struct packed {
      logic                   en;
      logic [`ETH_RX_AW-1:0]  addr;
      logic [7:0]             data;
   } buf_wr_t;

   // len counts every byte after the delimiter, FCS included
   typedef struct packed {
      logic        rcvd;
      logic        crc_err;
      logic [11:0] len;
   } rx_status_t;

endpackage

/* hdl/eth_rx_top.sv */
`timescale 1ns/1ps
`include "eth_rx_consts.svh"

module eth_rx_top (
   input  logic                   rx_clk_i,
   input  logic                   arst_i,
   input  logic                   rx_dv_i,
   input  logic [3:0]             rx_data_i,
   input  logic                   rcv_ack_i,
   input  logic [`ETH_RX_AW-1:0]  rd_addr_i,
   output logic [7:0]             rd_data_o,
   output eth_rx_pkg::rx_status_t status_o
);

   eth_rx_pkg::rx_byte_t cand;
   eth_rx_pkg::buf_wr_t  wr;

   logic        align;
   logic        crc_start;
   logic [31:0] crc;

   eth_rx_nibble_asm u_asm (
      .rx_clk_i  (rx_clk_i),
      .arst_i    (arst_i),
      .rx_dv_i   (rx_dv_i),
      .rx_data_i (rx_data_i),
      .align_i   (align),
      .cand_o    (cand)
   );

   eth_rx_ctrl u_ctrl (
      .rx_clk_i    (rx_clk_i),
      .arst_i      (arst_i),
      .rx_dv_i     (rx_dv_i),
      .cand_i      (cand),
      .rcv_ack_i   (rcv_ack_i),
      .crc_i       (crc),
      .align_o     (align),
      .crc_start_o (crc_start),
      .wr_o        (wr),
      .status_o    (status_o)
   );

   eth_rx_crc32 u_crc (
      .rx_clk_i (rx_clk_i),
      .arst_i   (arst_i),
      .start_i  (crc_start),
      .wr_i     (wr),
      .crc_o    (crc)
   );

   eth_rx_frame_buf u_buf (
      .rx_clk_i  (rx_clk_i),
      .wr_i      (wr),
      .rd_addr_i (rd_addr_i),
      .rd_data_o (rd_data_o)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the MII receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f eth_rx.f --top-module eth_rx_tb -o eth_rx_sim \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/eth_rx_sim > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* test/eth_rx_asserts.sv */
`timescale 1ns/1ps

module eth_rx_asserts (
   input logic                    clk_i,
   input logic                    arst_i,
   input logic                    rcv_ack_i,
   input logic                    align_i,
   input eth_rx_pkg::rx_byte_t    cand_i,
   input logic [11:0]             cnt_i,
   input eth_rx_pkg::ctrl_state_e state_i,
   input eth_rx_pkg::buf_wr_t     wr_i,
   input eth_rx_pkg::rx_status_t  status_i
);

   // Frame held until the host acknowledges
   rcvd_held: assert property (@(posedge clk_i) disable iff (arst_i)
      (status_i.rcvd && !rcv_ack_i) |=> status_i.rcvd)
      else $error("rcvd dropped without acknowledge");

   no_write_in_done: assert property (@(posedge clk_i) disable iff (arst_i)
      (state_i == eth_rx_pkg::DONE) |-> !wr_i.en)
      else $error("buffer written while frame pending");

   // Longer than the buffer
   no_addr_wrap: assert property (@(posedge clk_i) disable iff (arst_i)
      cnt_i <= 12'd2048)
      else $error("write address wrapped past 2047");

   // First nibble after the delimiter only half fills byte 0
   align_phase: assert property (@(posedge clk_i) disable iff (arst_i)
      align_i |=> !cand_i.vld)
      else $error("byte strobe out of phase after delimiter");

endmodule

/* test/eth_rx_tb.sv */
`timescale 1ns/1ps
`include "eth_rx_consts.svh"

module eth_rx_tb;

   typedef logic [7:0] byte_q_t[$];

   localparam int NUM_FRAMES        = 18;
   localparam int MAX_FRAME_NIBBLES = 2 * (8 + 6 + 200 + 4);
   localparam int MAX_READ_CYCLES   = 2 * (6 + 200 + 4);
   localparam int TIMEOUT_CYCLES    =
      NUM_FRAMES * (MAX_FRAME_NIBBLES + MAX_READ_CYCLES) + 2000;

   logic                   clk;
   logic                   por_rst;
   logic                   ext_rst;
   logic                   rx_dv;
   logic [3:0]             rx_data;
   logic                   rcv_ack;
   logic [`ETH_RX_AW-1:0]  rd_addr;
   logic [7:0]             rd_data;
   eth_rx_pkg::rx_status_t status;

   int errors;
   int cycles;

   eth_rx_tb_clk u_clk (
      .clk_o (clk),
      .rst_o (por_rst)
   );

   eth_rx_top uut (
      .rx_clk_i  (clk),
      .arst_i    (por_rst | ext_rst),
      .rx_dv_i   (rx_dv),
      .rx_data_i (rx_data),
      .rcv_ack_i (rcv_ack),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data),
      .status_o  (status)
   );

   bind eth_rx_ctrl eth_rx_asserts u_asserts (
      .clk_i     (rx_clk_i),
      .arst_i    (arst_i),
      .rcv_ack_i (rcv_ack_i),
      .align_i   (align_o),
      .cand_i    (cand_i),
      .cnt_i     (cnt),
      .state_i   (state),
      .wr_i      (wr_o),
      .status_i  (status_o)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
         $display("tests failed");
         $finish;
      end
   end

   // Reflected CRC-32, transmitted complement LSB first
   function automatic logic [31:0] fcs_of(input byte_q_t b);
      logic [31:0] c;
      c = 32'hffffffff;
      foreach (b[i]) begin
         c = c ^ {24'h0, b[i]};
         for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   task automatic build_frame(input logic [47:0] dst, input int plen, input bit corrupt,
                              output byte_q_t f);
      logic [31:0] fcs;
      f = {};
      for (int i = 5; i >= 0; i--) begin
         f.push_back(dst[i*8 +: 8]);
      end
      for (int i = 0; i < plen; i++) begin
         f.push_back(8'($urandom));
      end
      fcs = fcs_of(f);
      for (int i = 0; i < 4; i++) begin
         f.push_back(fcs[i*8 +: 8]);
      end
      if (corrupt) begin
         f[10] = f[10] ^ 8'h01;
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(posedge clk);
      rx_dv   <= 1'b1;
      rx_data <= b[3:0];
      @(posedge clk);
      rx_data <= b[7:4];
   endtask

   // Stopping early leaves rx_dv high for a mid-frame event
   task automatic send_frame(input byte_q_t f, input int pre_len, input int cut);
      for (int p = 0; p < pre_len; p++) begin
         send_byte(8'h55);
      end
      send_byte(`ETH_RX_SFD);
      for (int i = 0; i < cut; i++) begin
         send_byte(f[i]);
      end
      if (cut >= f.size()) begin
         @(posedge clk);
         rx_dv   <= 1'b0;
         rx_data <= 4'h0;
      end
   endtask

   task automatic check_status(input string what, input eth_rx_pkg::rx_status_t exp,
                               input eth_rx_pkg::rx_status_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s exp %h got %h", what, exp, act);
         errors++;
      end
   endtask

   task automatic check_byte(input string what, input logic [7:0] exp,
                             input logic [7:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s exp %h got %h", what, exp, act);
         errors++;
      end
   endtask

   task automatic wait_status(output bit got);
      got = 1'b0;
      for (int i = 0; i < 3 && !got; i++) begin
         @(negedge clk);
         got = status.rcvd;
      end
   endtask

   task automatic expect_status(input int len, input bit crc_err);
      eth_rx_pkg::rx_status_t exp;
      bit got;
      exp.rcvd    = 1'b1;
      exp.crc_err = crc_err;
      exp.len     = 12'(len);
      wait_status(got);
      if (!got) begin
         $display("Frame of %0d bytes was not reported within 3 cycles", len);
         errors++;
      end else begin
         check_status("status_o", exp, status);
      end
   endtask

   task automatic check_buffer(input byte_q_t f);
      for (int i = 0; i < f.size(); i++) begin
         @(posedge clk);
         rd_addr <= `ETH_RX_AW'(i);
         @(posedge clk);
         @(negedge clk);
         check_byte($sformatf("rd_data_o[%0d]", i), f[i], rd_data);
      end
   endtask

   task automatic ack_frame();
      @(posedge clk);
      rcv_ack <= 1'b1;
      @(posedge clk);
      rcv_ack <= 1'b0;
      @(negedge clk);
      check_status("status_o after ack", '0, status);
   endtask

   task automatic receive_good(input logic [47:0] dst, input int pre_len);
      byte_q_t f;
      build_frame(dst, 46 + int'($urandom % 155), 1'b0, f);
      send_frame(f, pre_len, f.size());
      expect_status(f.size(), 1'b0);
      check_buffer(f);
      ack_frame();
   endtask

   task automatic good_frame();
      receive_good(`ETH_RX_MAC_ADDR, 7);
   endtask

   task automatic crc_error_frame();
      byte_q_t f;
      build_frame(`ETH_RX_MAC_ADDR, 60, 1'b1, f);
      send_frame(f, 7, f.size());
      expect_status(f.size(), 1'b1);
      ack_frame();
      receive_good(`ETH_RX_MAC_ADDR, 7);
   endtask

   task automatic address_filter();
      byte_q_t f;
      bit got;
      receive_good({48{1'b1}}, 7);
      build_frame(48'h0a_bb_cc_dd_ee_ff, 50, 1'b0, f);
      send_frame(f, 7, f.size());
      wait_status(got);
      if (got) begin
         $display("Frame to a foreign address raised rcvd");
         errors++;
         ack_frame();
      end
      receive_good(`ETH_RX_MAC_ADDR, 7);
   endtask

   task automatic pending_frame();
      byte_q_t f1;
      byte_q_t f2;
      eth_rx_pkg::rx_status_t held;
      build_frame(`ETH_RX_MAC_ADDR, 80, 1'b0, f1);
      build_frame(`ETH_RX_MAC_ADDR, 120, 1'b1, f2);
      send_frame(f1, 7, f1.size());
      expect_status(f1.size(), 1'b0);
      held = status;
      send_frame(f2, 7, f2.size());
      repeat (4) @(negedge clk);
      check_status("status_o while pending", held, status);
      check_buffer(f1);
      ack_frame();
      receive_good(`ETH_RX_MAC_ADDR, 7);
   endtask

   task automatic preamble_and_reset();
      byte_q_t f;
      for (int pl = 1; pl <= 7; pl++) begin
         receive_good(`ETH_RX_MAC_ADDR, pl);
      end
      build_frame(`ETH_RX_MAC_ADDR, 100, 1'b0, f);
      send_frame(f, 7, 20);
      @(posedge clk);
      ext_rst <= 1'b1;
      @(posedge clk);
      rx_dv   <= 1'b0;
      rx_data <= 4'h0;
      repeat (3) @(posedge clk);
      ext_rst <= 1'b0;
      @(negedge clk);
      check_status("status_o after reset", '0, status);
      receive_good(`ETH_RX_MAC_ADDR, 7);
   endtask

   initial begin
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      rcv_ack = 1'b0;
      rd_addr = '0;
      ext_rst = 1'b0;
      errors  = 0;
      cycles  = 0;
      void'($urandom(32'he128));
      @(negedge por_rst);
      @(negedge clk);
      check_status("status_o after reset", '0, status);
      good_frame();
      crc_error_frame();
      address_filter();
      pending_frame();
      preamble_and_reset();
      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* test/eth_rx_tb_clk.sv */
`timescale 1ns/1ps

module eth_rx_tb_clk (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   // Power-on reset for 8 cycles
   initial begin
      rst_o = 1'b1;
      repeat (8) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule
